//--- verilog/beam_pick_cfg.svh
// Beam memory picker configuration
// Lane, bank and width constants shared by the datapath blocks

`ifndef BEAM_PICK_CFG_SVH
`define BEAM_PICK_CFG_SVH

// Lanes per word and banks per first symbol
`define BP_LANES        16
`define BP_BANKS        4
`define BP_BEAMS        (`BP_LANES * `BP_BANKS)

// Sample, address and index widths
`define BP_DATA_W       40
`define BP_ADDR_W       11
`define BP_IDX_W        6

// Header and gain byte widths
`define BP_INFO0_W      64
`define BP_AGC_W        8

`define BP_POL_SPLIT    32
`define BP_BANK_RD_LAT  2

`endif

//--- verilog/beam_pick_pkg.sv
// Beam memory picker types
// Sample, address, index and gain types plus the control enums

`include "beam_pick_cfg.svh"

package beam_pick_pkg;

    typedef logic [`BP_DATA_W-1:0]  beam_word_t;
    typedef logic [`BP_ADDR_W-1:0]  bank_addr_t;
    typedef logic [`BP_IDX_W-1:0]   beam_idx_t;
    typedef logic [`BP_AGC_W-1:0]   agc_t;
    typedef logic [`BP_INFO0_W-1:0] info0_t;

    // One word of all lanes, and the per-lane side arrays
    typedef beam_word_t [`BP_LANES-1:0] lane_data_t;
    typedef beam_idx_t  [`BP_LANES-1:0] lane_idx_t;
    typedef agc_t       [`BP_LANES-1:0] lane_agc_t;
    typedef agc_t       [1:0]           agc_pair_t;

    typedef logic       [`BP_BANKS-1:0] bank_sel_t;
    typedef lane_data_t [`BP_BANKS-1:0] bank_data_t;

    typedef enum logic {RD_IDLE, RD_SWEEP} rd_state_e;
    typedef enum logic {OUT_PASS, OUT_SORTED} out_src_e;

endpackage

//--- verilog/beam_write_ctrl.sv
// First-symbol write control
// Steers each packet into its own bank and tracks the packet length

`include "beam_pick_cfg.svh"

module beam_write_ctrl
    import beam_pick_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_sym_1st,
    input  logic       i_wr_wen,
    input  logic       i_wr_eop,
    input  lane_data_t i_wr_data,
    output bank_sel_t  o_bank_wen,
    output bank_addr_t o_wr_addr,
    output lane_data_t o_wr_data,
    output bank_addr_t o_last_addr
);

    logic                         wen_1st;
    logic                         eop_1st;
    logic                         eop_d1;
    logic                         sym_1st_d1;
    logic [$clog2(`BP_BANKS)-1:0] blk_cnt;

    // Only first-symbol traffic goes to the banks
    assign wen_1st = i_wr_wen & i_sym_1st;
    assign eop_1st = i_wr_eop & i_sym_1st;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            eop_d1     <= 1'b0;
            sym_1st_d1 <= 1'b0;
            blk_cnt    <= '0;
            o_bank_wen <= '0;
            o_wr_addr  <= '0;
            o_last_addr <= '0;
        end else begin
            eop_d1     <= eop_1st;
            sym_1st_d1 <= i_sym_1st;

            // Packet counter selects one bank per packet
            if (!sym_1st_d1)
                blk_cnt <= '0;
            else if (eop_1st)
                blk_cnt <= blk_cnt + 1'b1;

            o_bank_wen <= wen_1st ? bank_sel_t'(1) << blk_cnt : '0;

            // Shared address restarts after every packet
            if (!sym_1st_d1 || eop_d1)
                o_wr_addr <= '0;
            else if (|o_bank_wen)
                o_wr_addr <= o_wr_addr + 1'b1;

            // Final word address of the packet just written
            if (eop_d1)
                o_last_addr <= o_wr_addr;
        end
    end

    // Data register shared by all banks
    always_ff @(posedge i_clk) begin
        o_wr_data <= i_wr_data;
    end

endmodule

//--- verilog/beam_bank.sv
// One beam memory bank
// Simple dual-port lane memory with registered address and output

`include "beam_pick_cfg.svh"

module beam_bank
    import beam_pick_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_wen,
    input  logic       i_rd_en,
    input  bank_addr_t i_wr_addr,
    input  bank_addr_t i_rd_addr,
    input  lane_data_t i_wr_data,
    output lane_data_t o_rd_data
);

    localparam int DEPTH = 2 ** `BP_ADDR_W;

    lane_data_t mem [DEPTH];
    bank_addr_t rd_addr_q;

    //----------------------------------------------------------------------
    // Write port
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wen)
            mem[i_wr_addr] <= i_wr_data;
    end

    //----------------------------------------------------------------------
    // Two-stage read port
    //----------------------------------------------------------------------
    // Address held while the sweep is idle
    always_ff @(posedge i_clk) begin
        if (i_rd_en)
            rd_addr_q <= i_rd_addr;
    end

    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[rd_addr_q];
    end

endmodule

//--- verilog/beam_read_ctrl.sv
// Sort read control
// Sweeps all banks on a sort start edge and aligns the stream markers

`include "beam_pick_cfg.svh"

module beam_read_ctrl
    import beam_pick_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_sort_sop,
    input  bank_addr_t i_last_addr,
    output logic       o_rd_en,
    output bank_addr_t o_rd_addr,
    output logic       o_sort_vld,
    output logic       o_sort_sop,
    output logic       o_sort_eop
);

    // Bank latency plus matrix and pick stages of the reorder
    localparam int DLY = `BP_BANK_RD_LAT + 2;

    rd_state_e            rd_state;
    logic                 sort_sop_d;
    logic                 sop_rise;
    logic                 at_last;
    logic [2:0]           mark;
    logic [DLY-1:0][2:0]  mark_q;

    //----------------------------------------------------------------------
    // Start edge and sweep FSM
    //----------------------------------------------------------------------
    assign sop_rise = i_sort_sop & ~sort_sop_d;
    assign at_last  = (o_rd_addr == i_last_addr);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sort_sop_d <= 1'b0;
            rd_state   <= RD_IDLE;
            o_rd_addr  <= '0;
        end else begin
            sort_sop_d <= i_sort_sop;
            case (rd_state)
                RD_IDLE: begin
                    if (sop_rise) begin
                        rd_state  <= RD_SWEEP;
                        o_rd_addr <= '0;
                    end
                end
                RD_SWEEP: begin
                    if (at_last)
                        rd_state <= RD_IDLE;
                    else
                        o_rd_addr <= o_rd_addr + 1'b1;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    assign o_rd_en = (rd_state == RD_SWEEP);

    //----------------------------------------------------------------------
    // Marker delay line
    //----------------------------------------------------------------------
    // {last, first, valid} for the address issued this cycle
    assign mark = {o_rd_en & at_last, o_rd_en & (o_rd_addr == '0), o_rd_en};

    always_ff @(posedge i_clk) begin
        if (i_reset)
            mark_q <= '0;
        else
            mark_q <= {mark_q[DLY-2:0], mark};
    end

    assign o_sort_vld = mark_q[DLY-1][0];
    assign o_sort_sop = mark_q[DLY-1][1];
    assign o_sort_eop = mark_q[DLY-1][2];

endmodule

//--- verilog/beam_reorder.sv
// Beam reorder
// Forms the 64-beam matrix from the banks and picks one beam per lane

`include "beam_pick_cfg.svh"

module beam_reorder
    import beam_pick_pkg::*;
(
    input  logic       i_clk,
    input  bank_data_t i_bank_data,
    input  lane_idx_t  i_sort_idx,
    input  agc_pair_t  i_info_1,
    output lane_data_t o_beam_data,
    output lane_agc_t  o_agc
);

    beam_word_t [`BP_BEAMS-1:0] matrix_q;

    //----------------------------------------------------------------------
    // Matrix stage
    //----------------------------------------------------------------------
    // Bank b lane l lands on beam b*16+l
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < `BP_BANKS; b++) begin
            for (int l = 0; l < `BP_LANES; l++) begin
                matrix_q[b*`BP_LANES+l] <= i_bank_data[b][l];
            end
        end
    end

    //----------------------------------------------------------------------
    // Pick stage
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < `BP_LANES; i++) begin
            o_beam_data[i] <= matrix_q[i_sort_idx[i]];
        end
    end

    // Upper half of the beams is odd polarity
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < `BP_LANES; i++) begin
            if (i_sort_idx[i] >= `BP_POL_SPLIT)
                o_agc[i] <= i_info_1[1];
            else
                o_agc[i] <= i_info_1[0];
        end
    end

endmodule

//--- verilog/beam_out_stage.sv
// Output stage
// Chooses sorted or pass-through stream and drives the header outputs

`include "beam_pick_cfg.svh"

module beam_out_stage
    import beam_pick_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_sym_1st,
    input  logic       i_rvalid,
    input  logic       i_wr_sop,
    input  logic       i_wr_eop,
    input  lane_data_t i_wr_data,
    input  lane_data_t i_beam_data,
    input  lane_agc_t  i_agc,
    input  info0_t     i_info_0,
    input  logic       i_sort_vld,
    input  logic       i_sort_sop,
    input  logic       i_sort_eop,
    output logic       o_tvalid,
    output logic       o_sop,
    output logic       o_eop,
    output lane_data_t o_rd_data,
    output info0_t     o_info_0,
    output lane_agc_t  o_info_1
);

    logic     win_q;
    out_src_e src;
    info0_t   hdr_q;
    info0_t   hdr_next;

    //----------------------------------------------------------------------
    // First-symbol window
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset)
            win_q <= 1'b0;
        else if (i_sym_1st)
            win_q <= 1'b1;
        else if (i_sort_eop)
            win_q <= 1'b0;
    end

    assign src = (i_sym_1st || win_q) ? OUT_SORTED : OUT_PASS;

    // Header taken with the first sorted word
    assign hdr_next = i_sort_sop ? i_info_0 : hdr_q;

    always_ff @(posedge i_clk) begin
        hdr_q <= hdr_next;
    end

    //----------------------------------------------------------------------
    // Output registers
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tvalid <= 1'b0;
            o_sop    <= 1'b0;
            o_eop    <= 1'b0;
            o_info_1 <= '0;
        end else begin
            o_tvalid <= (src == OUT_SORTED) ? i_sort_vld : i_rvalid;
            o_sop    <= (src == OUT_SORTED) ? i_sort_sop : i_wr_sop;
            o_eop    <= (src == OUT_SORTED) ? i_sort_eop : i_wr_eop;
            // Gain only on sorted valid words
            for (int l = 0; l < `BP_LANES; l++) begin
                o_info_1[l] <= (src == OUT_SORTED && i_sort_vld) ? i_agc[l] : '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_rd_data <= (src == OUT_SORTED) ? i_beam_data : i_wr_data;
        o_info_0  <= (src == OUT_SORTED) ? hdr_next : i_info_0;
    end

endmodule

//--- verilog/beam_mem_pick.sv
// Beam memory picker top
// Banks the first symbol, then streams 16 beams picked by index

module beam_mem_pick
    import beam_pick_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_rvalid,
    input  logic       i_wr_wen,
    input  logic       i_wr_sop,
    input  logic       i_wr_eop,
    input  lane_data_t i_wr_data,
    input  lane_idx_t  i_sort_idx,
    input  logic       i_sort_sop,
    input  logic       i_sym_1st,
    input  info0_t     i_info_0,
    input  agc_pair_t  i_info_1,
    output info0_t     o_info_0,
    output lane_agc_t  o_info_1,
    output lane_data_t o_rd_data,
    output logic       o_sop,
    output logic       o_eop,
    output logic       o_tvalid
);

    bank_sel_t  bank_wen;
    bank_addr_t wr_addr;
    lane_data_t wr_data;
    bank_addr_t last_addr;
    logic       rd_en;
    bank_addr_t rd_addr;
    bank_data_t bank_data;
    logic       sort_vld;
    logic       sort_sop;
    logic       sort_eop;
    lane_data_t beam_data;
    lane_agc_t  agc;

    beam_write_ctrl u_write_ctrl (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_sym_1st  (i_sym_1st),
        .i_wr_wen   (i_wr_wen),
        .i_wr_eop   (i_wr_eop),
        .i_wr_data  (i_wr_data),
        .o_bank_wen (bank_wen),
        .o_wr_addr  (wr_addr),
        .o_wr_data  (wr_data),
        .o_last_addr(last_addr)
    );

    // One bank per first-symbol packet
    for (genvar gb = 0; gb < $bits(bank_sel_t); gb++) begin : g_bank
        beam_bank u_bank (
            .i_clk    (i_clk),
            .i_wen    (bank_wen[gb]),
            .i_rd_en  (rd_en),
            .i_wr_addr(wr_addr),
            .i_rd_addr(rd_addr),
            .i_wr_data(wr_data),
            .o_rd_data(bank_data[gb])
        );
    end

    beam_read_ctrl u_read_ctrl (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_sort_sop (i_sort_sop),
        .i_last_addr(last_addr),
        .o_rd_en    (rd_en),
        .o_rd_addr  (rd_addr),
        .o_sort_vld (sort_vld),
        .o_sort_sop (sort_sop),
        .o_sort_eop (sort_eop)
    );

    beam_reorder u_reorder (
        .i_clk      (i_clk),
        .i_bank_data(bank_data),
        .i_sort_idx (i_sort_idx),
        .i_info_1   (i_info_1),
        .o_beam_data(beam_data),
        .o_agc      (agc)
    );

    beam_out_stage u_out_stage (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_sym_1st  (i_sym_1st),
        .i_rvalid   (i_rvalid),
        .i_wr_sop   (i_wr_sop),
        .i_wr_eop   (i_wr_eop),
        .i_wr_data  (i_wr_data),
        .i_beam_data(beam_data),
        .i_agc      (agc),
        .i_info_0   (i_info_0),
        .i_sort_vld (sort_vld),
        .i_sort_sop (sort_sop),
        .i_sort_eop (sort_eop),
        .o_tvalid   (o_tvalid),
        .o_sop      (o_sop),
        .o_eop      (o_eop),
        .o_rd_data  (o_rd_data),
        .o_info_0   (o_info_0),
        .o_info_1   (o_info_1)
    );

endmodule

//--- verification/tb_beam_mem_pick.sv
// Beam memory picker testbench
// Writes first-symbol packets, sorts by random index and checks the stream

`include "beam_pick_cfg.svh"

module tb_beam_mem_pick
    import beam_pick_pkg::*;
;

    logic       i_clk = 1'b0;
    logic       i_reset;
    logic       i_rvalid, i_wr_wen, i_wr_sop, i_wr_eop, i_sort_sop, i_sym_1st;
    lane_data_t i_wr_data;
    lane_idx_t  i_sort_idx;
    info0_t     i_info_0;
    agc_pair_t  i_info_1;
    info0_t     o_info_0;
    lane_agc_t  o_info_1;
    lane_data_t o_rd_data;
    logic       o_sop, o_eop, o_tvalid;

    // Model of the banked symbol per beam and word
    beam_word_t mdl [`BP_BEAMS][8];
    logic [31:0] rng = 32'h2360_bb50;
    int         errors = 0;
    int         tests = 0;
    int         k, n_words;
    logic       rst_chk = 0, sort_chk = 0, pass_chk = 0;
    info0_t     hdr;
    logic       p_rvalid, p_sop, p_eop;
    lane_data_t p_data;
    info0_t     p_info0;

    beam_mem_pick UUT (.*);

    always #10 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic note_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endtask

    //----------------------------------------------------------------------
    // Output checks on the falling edge
    //----------------------------------------------------------------------
    always @(posedge i_clk) begin
        p_rvalid = i_rvalid;
        p_sop    = i_wr_sop;
        p_eop    = i_wr_eop;
        p_data   = i_wr_data;
        p_info0  = i_info_0;
    end

    always @(negedge i_clk) begin
        if (rst_chk) begin
            assert (!o_tvalid && !o_sop && !o_eop && o_info_1 == '0)
                else note_error("outputs not idle after reset");
        end
        if (sort_chk && o_tvalid) begin
            for (int i = 0; i < `BP_LANES; i++) begin
                assert (o_rd_data[i] === mdl[i_sort_idx[i]][k])
                    else note_error($sformatf("word %0d lane %0d beam mismatch", k, i));
                assert (o_info_1[i] === (i_sort_idx[i] >= 6'd32 ? i_info_1[1] : i_info_1[0]))
                    else note_error($sformatf("word %0d lane %0d gain mismatch", k, i));
            end
            assert (o_info_0 === hdr) else note_error("header mismatch");
            assert (o_sop === (k == 0)) else note_error("o_sop misplaced");
            assert (o_eop === (k == n_words - 1)) else note_error("o_eop misplaced");
            k++;
        end
        if (pass_chk) begin
            assert (o_tvalid === p_rvalid && o_sop === p_sop && o_eop === p_eop)
                else note_error("pass-through strobes differ");
            assert (o_rd_data === p_data && o_info_0 === p_info0)
                else note_error("pass-through data differ");
            assert (o_info_1 == '0) else note_error("gain not zero in pass-through");
        end
    end

    //----------------------------------------------------------------------
    // Stimulus tasks
    //----------------------------------------------------------------------
    task automatic write_symbol(input int n);
        for (int p = 0; p < `BP_BANKS; p++) begin
            for (int w = 0; w < n; w++) begin
                @(negedge i_clk);
                i_wr_wen = 1'b1;
                i_rvalid = 1'b1;
                i_wr_sop = (w == 0);
                i_wr_eop = (w == n - 1);
                for (int l = 0; l < `BP_LANES; l++) begin
                    rng = xorshift(rng);
                    i_wr_data[l] = {rng[7:0], rng};
                    mdl[p*`BP_LANES+l][w] = i_wr_data[l];
                end
            end
            @(negedge i_clk);
            {i_wr_wen, i_rvalid, i_wr_sop, i_wr_eop} = '0;
        end
    endtask

    task automatic sort_symbol(input int n);
        int  err0;
        logic done;
        err0 = errors;
        done = 1'b0;
        for (int l = 0; l < `BP_LANES; l++) begin
            rng = xorshift(rng);
            i_sort_idx[l] = rng[5:0];
        end
        rng = xorshift(rng);
        i_info_1 = rng[15:0];
        rng = xorshift(rng);
        i_info_0[63:32] = rng;
        rng = xorshift(rng);
        i_info_0[31:0] = rng;
        hdr = i_info_0;
        n_words = n;
        k = 0;
        sort_chk = 1'b1;
        @(negedge i_clk);
        i_sort_sop = 1'b1;
        @(negedge i_clk);
        i_sort_sop = 1'b0;
        i_sym_1st = 1'b0;
        for (int t = 0; t < 60 && !done; t++) begin
            @(negedge i_clk);
            done = o_eop;
        end
        if (!done) begin
            $display("Timeout: no end of sorted stream after %0d words", k);
            errors++;
        end
        @(negedge i_clk);
        sort_chk = 1'b0;
        assert (k == n) else note_error($sformatf("%0d valid words, expected %0d", k, n));
        tests++;
        $display("Test sort %0d words: %0d errors", n, errors - err0);
    endtask

    //----------------------------------------------------------------------
    // Sequence
    //----------------------------------------------------------------------
    initial begin
        int err0;
        i_reset = 1'b1;
        {i_rvalid, i_wr_wen, i_wr_sop, i_wr_eop, i_sort_sop, i_sym_1st} = '0;
        i_wr_data = '0;
        i_sort_idx = '0;
        i_info_0 = '0;
        i_info_1 = '0;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        rst_chk = 1'b1;
        repeat (5) @(negedge i_clk);
        rst_chk = 1'b0;
        tests++;
        $display("Test reset: %0d errors", errors);

        i_sym_1st = 1'b1;
        write_symbol(8);
        sort_symbol(8);

        // Later symbol traffic straight through
        err0 = errors;
        @(negedge i_clk);
        pass_chk = 1'b1;
        for (int c = 0; c < 24; c++) begin
            @(negedge i_clk);
            rng = xorshift(rng);
            {i_rvalid, i_wr_sop, i_wr_eop} = rng[2:0];
            i_info_0 = {rng, ~rng};
            for (int l = 0; l < `BP_LANES; l++) begin
                rng = xorshift(rng);
                i_wr_data[l] = {rng[15:8], rng};
            end
        end
        @(negedge i_clk);
        pass_chk = 1'b0;
        {i_rvalid, i_wr_sop, i_wr_eop} = '0;
        tests++;
        $display("Test pass-through: %0d errors", errors - err0);

        @(negedge i_clk);
        i_sym_1st = 1'b1;
        write_symbol(5);
        sort_symbol(5);

        $display("Tests: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- beam_mem_pick.f
+incdir+verilog
verilog/beam_pick_pkg.sv
verilog/beam_write_ctrl.sv
verilog/beam_bank.sv
verilog/beam_read_ctrl.sv
verilog/beam_reorder.sv
verilog/beam_out_stage.sv
verilog/beam_mem_pick.sv
verification/tb_beam_mem_pick.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the beam memory picker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f beam_mem_pick.f \
    --top-module tb_beam_mem_pick \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_beam_mem_pick)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
    exit 0
fi
exit 1
